// ==== testbench/rs_alu_cases.txt ====
# C dv inst rd op tag1 tag2 src_ready wake_valid wake_tag0 wake_tag1 wake_tag2 (hex)
# I idle_cycles (dec), E delay_after_last_cycle (dec) inst rd tag1 tag2 (hex)
I 3
# both operands ready at dispatch
C 1 1 10 0 01 02 3 0 00 00 00
E 2 1 10 01 02
I 4
# src2 waits for a load broadcast
C 1 2 11 1 03 04 1 0 00 00 00
I 4
C 0 0 00 0 00 00 0 4 00 00 04
E 2 2 11 03 04
I 3
# both tags broadcast in the dispatch cycle
C 1 3 12 2 05 06 0 3 05 06 00
E 2 3 12 05 06
I 3
# a younger ready entry passes older waiting ones
C 1 4 13 3 07 08 0 0 00 00 00
C 1 5 14 4 09 0a 2 0 00 00 00
C 1 6 15 5 0b 0c 3 0 00 00 00
E 2 6 15 0b 0c
C 0 0 00 0 00 00 0 3 07 09 00
E 2 5 14 09 0a
C 0 0 00 0 00 00 0 4 00 00 08
E 2 4 13 07 08
I 3
# one broadcast readies three entries, oldest goes first
C 1 7 16 6 0d 0e 1 0 00 00 00
C 1 8 17 7 0e 0f 2 0 00 00 00
C 1 9 18 8 10 0e 1 0 00 00 00
C 0 0 00 0 00 00 0 2 00 0e 00
E 2 7 16 0d 0e
E 3 8 17 0e 0f
E 4 9 18 10 0e
I 4
# head blocked at slot 9, the ready entry in slot 1 sits outside the window
C 1 0a 20 9 20 21 1 0 00 00 00
C 1 0b 21 0 22 23 1 0 00 00 00
C 1 0c 22 1 22 23 1 0 00 00 00
C 1 0d 23 2 22 23 1 0 00 00 00
C 1 0e 24 3 22 23 1 0 00 00 00
C 1 0f 25 4 22 23 1 0 00 00 00
C 1 10 26 5 22 23 1 0 00 00 00
C 1 11 27 6 22 23 1 0 00 00 00
C 1 12 28 7 24 25 3 0 00 00 00
I 5
C 0 0 00 0 00 00 0 2 00 21 00
E 2 0a 20 20 21
E 3 12 28 24 25
I 3
# drain across the wrap of tail and head
C 0 0 00 0 00 00 0 1 23 00 00
E 2 0b 21 22 23
E 3 0c 22 22 23
E 4 0d 23 22 23
E 5 0e 24 22 23
E 6 0f 25 22 23
E 7 10 26 22 23
E 8 11 27 22 23
I 10
C 1 13 29 8 26 27 3 0 00 00 00
E 2 13 29 26 27

// ==== rs_alu.f ====
hw/rs_alu_pkg.sv
hw/rs_entry_table.sv
hw/rs_wakeup.sv
hw/rs_issue_select.sv
hw/rs_alu.sv
testbench/tb_rs_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rs_alu
FILELIST  ?= rs_alu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_rs_alu.sv ====
`default_nettype none

module tb_rs_alu;
    timeunit 1ns;
    timeprecision 100ps;

    import rs_alu_pkg::*;

    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int ISSUE_TIMEOUT = 50;

    logic       clk;
    logic       reset;
    logic       dispatch_valid;
    inst_num_t  inst_num;
    word_t      pc;
    phys_tag_t  rd;
    alu_op_e    alu_op;
    logic       src1_sel;
    logic       src2_sel;
    word_t      imm;
    phys_tag_t  src1_tag;
    phys_tag_t  src2_tag;
    logic [1:0] src_ready;
    logic       wake_valid [NUM_WAKE];
    phys_tag_t  wake_tag   [NUM_WAKE];
    logic       issue_valid;
    inst_num_t  issue_inst_num;
    word_t      issue_pc;
    phys_tag_t  issue_rd;
    alu_op_e    issue_alu_op;
    logic       issue_src1_sel;
    logic       issue_src2_sel;
    word_t      issue_imm;
    phys_tag_t  issue_src1_tag;
    phys_tag_t  issue_src2_tag;

    // fields of the cycle line being driven
    logic       f_dv;
    inst_num_t  f_inst;
    phys_tag_t  f_rd;
    logic [3:0] f_op;
    phys_tag_t  f_t1;
    phys_tag_t  f_t2;
    logic [1:0] f_rdy;
    logic [2:0] f_wv;
    phys_tag_t  f_wt [NUM_WAKE];

    // expected issues in order, filled from the case file
    int        exp_cyc  [$];
    inst_num_t exp_inst [$];
    phys_tag_t exp_rd   [$];
    phys_tag_t exp_t1   [$];
    phys_tag_t exp_t2   [$];
    int        next_exp = 0;    // advanced by the issue monitor only

    // payload as dispatched, keyed by inst_num
    word_t      sent_pc  [inst_num_t];
    word_t      sent_imm [inst_num_t];
    logic [3:0] sent_op  [inst_num_t];
    logic [1:0] sent_sel [inst_num_t];

    int          cyc       = 0;
    logic [31:0] rng_state = 32'h931e;

    rs_alu dut (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fresh_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic phys_tag_t filler_tag();
        logic [31:0] r;
        r = fresh_rand();
        return {1'b1, r[6:0]};   // case tags all sit below 8'h80
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
            fail_run($sformatf("** Error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        @(posedge clk);
        #DRIVE_DLY;
        cyc            = cyc + 1;
        r              = fresh_rand();
        dispatch_valid = f_dv;
        inst_num       = f_inst;
        rd             = f_rd;
        alu_op         = alu_op_e'(f_op);
        src1_tag       = f_t1;
        src2_tag       = f_t2;
        src_ready      = f_rdy;
        src1_sel       = r[0];
        src2_sel       = r[1];
        pc             = fresh_rand();
        imm            = fresh_rand();
        for (int w = 0; w < NUM_WAKE; w++) begin
            wake_valid[w] = f_wv[w];
            wake_tag[w]   = f_wv[w] ? f_wt[w] : filler_tag();   // idle buses carry junk
        end
        if (f_dv) begin
            sent_pc[f_inst]  = pc;
            sent_imm[f_inst] = imm;
            sent_op[f_inst]  = f_op;
            sent_sel[f_inst] = {src2_sel, src1_sel};
        end
    endtask

    task automatic drive_idle();
        f_dv = 1'b0;
        f_wv = '0;
        drive_cycle();
    endtask

    task automatic check_issue(input int idx);
        compare("issue_valid cycle", cyc, exp_cyc[idx]);
        compare("issue_inst_num", issue_inst_num, exp_inst[idx]);
        compare("issue_rd", 32'(issue_rd), 32'(exp_rd[idx]));
        compare("issue_src1_tag", 32'(issue_src1_tag), 32'(exp_t1[idx]));
        compare("issue_src2_tag", 32'(issue_src2_tag), 32'(exp_t2[idx]));
        if (!sent_pc.exists(issue_inst_num)) begin
            fail_run($sformatf("inst %h issued but was never dispatched", issue_inst_num));
        end else begin
            compare("issue_pc", issue_pc, sent_pc[issue_inst_num]);
            compare("issue_imm", issue_imm, sent_imm[issue_inst_num]);
            compare("issue_alu_op", 32'(issue_alu_op), 32'(sent_op[issue_inst_num]));
            compare("issue_src_sel", 32'({issue_src2_sel, issue_src1_sel}),
                    32'(sent_sel[issue_inst_num]));
        end
    endtask

    // issue outputs are registered, so mid-cycle is a quiet point to look
    always @(negedge clk) begin
        if (!reset && issue_valid) begin
            if (next_exp >= exp_inst.size()) begin
                fail_run($sformatf("inst %h issued with no issue expected", issue_inst_num));
            end else begin
                check_issue(next_exp);
                next_exp = next_exp + 1;
            end
        end
    end

    initial begin
        int           fd;
        int           code;
        int           n;
        int           delay;
        int           waited;
        int           seen;
        logic [7:0]   kind;
        logic [1023:0] rest;
        inst_num_t    e_inst;
        phys_tag_t    e_rd;
        phys_tag_t    e_t1;
        phys_tag_t    e_t2;

        reset          = 1'b1;
        dispatch_valid = 1'b0;
        inst_num       = '0;
        pc             = '0;
        rd             = '0;
        alu_op         = OP_ADD;
        src1_sel       = 1'b0;
        src2_sel       = 1'b0;
        imm            = '0;
        src1_tag       = '0;
        src2_tag       = '0;
        src_ready      = '0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            wake_valid[w] = 1'b0;
            wake_tag[w]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        fd = $fopen("testbench/rs_alu_cases.txt", "r");
        if (fd == 0)
            fail_run("could not open testbench/rs_alu_cases.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                break;
            case (kind)
                "#": code = $fgets(rest, fd);
                "I": begin
                    code = $fscanf(fd, "%d", n);
                    repeat (n) drive_idle();
                end
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_dv, f_inst, f_rd,
                                   f_op, f_t1, f_t2, f_rdy, f_wv, f_wt[0], f_wt[1], f_wt[2]);
                    if (code != 11)
                        fail_run("cycle line in the case file is malformed");
                    drive_cycle();
                end
                "E": begin
                    code = $fscanf(fd, "%d %h %h %h %h", delay, e_inst, e_rd, e_t1, e_t2);
                    if (code != 5)
                        fail_run("expect line in the case file is malformed");
                    exp_cyc.push_back(cyc + delay);   // relative to the last driven cycle
                    exp_inst.push_back(e_inst);
                    exp_rd.push_back(e_rd);
                    exp_t1.push_back(e_t1);
                    exp_t2.push_back(e_t2);
                end
                default: fail_run("case file holds an unknown record type");
            endcase
        end
        $fclose(fd);

        waited = 0;
        seen   = next_exp;
        while (next_exp < exp_inst.size()) begin
            drive_idle();
            if (next_exp != seen) begin
                seen   = next_exp;
                waited = 0;
            end else begin
                waited = waited + 1;
                if (waited >= ISSUE_TIMEOUT)
                    fail_run($sformatf("inst %h never issued within %0d cycles",
                                       exp_inst[next_exp], ISSUE_TIMEOUT));
            end
        end
        repeat (4) drive_idle();   // a second issue of anything shows up here
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rs_alu.sv ====
`default_nettype none

module rs_alu (
    input  logic                  clk,
    input  logic                  reset,
    // dispatch
    input  logic                  dispatch_valid,
    input  rs_alu_pkg::inst_num_t inst_num,
    input  rs_alu_pkg::word_t     pc,
    input  rs_alu_pkg::phys_tag_t rd,
    input  rs_alu_pkg::alu_op_e   alu_op,
    input  logic                  src1_sel,
    input  logic                  src2_sel,
    input  rs_alu_pkg::word_t     imm,
    input  rs_alu_pkg::phys_tag_t src1_tag,
    input  rs_alu_pkg::phys_tag_t src2_tag,
    input  logic [1:0]            src_ready,
    // result broadcasts: alu, mul, load
    input  logic                  wake_valid [rs_alu_pkg::NUM_WAKE],
    input  rs_alu_pkg::phys_tag_t wake_tag   [rs_alu_pkg::NUM_WAKE],
    // issue, no back-pressure
    output logic                  issue_valid,
    output rs_alu_pkg::inst_num_t issue_inst_num,
    output rs_alu_pkg::word_t     issue_pc,
    output rs_alu_pkg::phys_tag_t issue_rd,
    output rs_alu_pkg::alu_op_e   issue_alu_op,
    output logic                  issue_src1_sel,
    output logic                  issue_src2_sel,
    output rs_alu_pkg::word_t     issue_imm,
    output rs_alu_pkg::phys_tag_t issue_src1_tag,
    output rs_alu_pkg::phys_tag_t issue_src2_tag
);
    import rs_alu_pkg::*;

    logic [RS_DEPTH-1:0] occupied;
    logic [RS_DEPTH-1:0] rdy1;
    logic [RS_DEPTH-1:0] rdy2;
    phys_tag_t           tag1_arr [RS_DEPTH];
    phys_tag_t           tag2_arr [RS_DEPTH];
    rs_idx_t             head;

    logic [RS_DEPTH-1:0] set1_mask;
    logic [RS_DEPTH-1:0] set2_mask;
    logic                disp_hit1;
    logic                disp_hit2;

    logic    grant_valid;
    rs_idx_t grant_idx;

    rs_entry_table u_table (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .inst_num       (inst_num),
        .pc             (pc),
        .rd             (rd),
        .alu_op         (alu_op),
        .src1_sel       (src1_sel),
        .src2_sel       (src2_sel),
        .imm            (imm),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .src_ready      (src_ready),
        .set1_mask      (set1_mask),
        .set2_mask      (set2_mask),
        .disp_hit1      (disp_hit1),
        .disp_hit2      (disp_hit2),
        .grant_valid    (grant_valid),
        .grant_idx      (grant_idx),
        .occupied       (occupied),
        .rdy1           (rdy1),
        .rdy2           (rdy2),
        .tag1_arr       (tag1_arr),
        .tag2_arr       (tag2_arr),
        .head           (head),
        .issue_valid    (issue_valid),
        .issue_inst_num (issue_inst_num),
        .issue_pc       (issue_pc),
        .issue_rd       (issue_rd),
        .issue_alu_op   (issue_alu_op),
        .issue_src1_sel (issue_src1_sel),
        .issue_src2_sel (issue_src2_sel),
        .issue_imm      (issue_imm),
        .issue_src1_tag (issue_src1_tag),
        .issue_src2_tag (issue_src2_tag)
    );

    // compares against stored tags and the tags arriving with this dispatch
    rs_wakeup u_wakeup (
        .wake_valid (wake_valid),
        .wake_tag   (wake_tag),
        .tag1_arr   (tag1_arr),
        .tag2_arr   (tag2_arr),
        .rdy1       (rdy1),
        .rdy2       (rdy2),
        .occupied   (occupied),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .set1_mask  (set1_mask),
        .set2_mask  (set2_mask),
        .disp_hit1  (disp_hit1),
        .disp_hit2  (disp_hit2)
    );

    rs_issue_select u_select (
        .occupied    (occupied),
        .rdy1        (rdy1),
        .rdy2        (rdy2),
        .head        (head),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

endmodule

`default_nettype wire

// ==== hw/rs_issue_select.sv ====
`default_nettype none

module rs_issue_select (
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] occupied,
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] rdy1,
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] rdy2,
    input  rs_alu_pkg::rs_idx_t             head,
    output logic                            grant_valid,
    output rs_alu_pkg::rs_idx_t             grant_idx
);
    import rs_alu_pkg::*;

    logic [RS_DEPTH-1:0] ready_mask;

    assign ready_mask = occupied & rdy1 & rdy2;

    // oldest first: walk the window outward from head, first hit wins
    always_comb begin
        rs_idx_t slot;

        grant_valid = 1'b0;
        grant_idx   = head;
        for (int k = 0; k < RS_WINDOW; k++) begin
            slot = head + rs_idx_t'(k);   // index width wraps at RS_DEPTH
            if (!grant_valid && ready_mask[slot]) begin
                grant_valid = 1'b1;
                grant_idx   = slot;
            end
        end
    end

    // ready bits only ever sit on live entries, freed slots come back clean
    always_comb begin
        assert (((rdy1 | rdy2) & ~occupied) == '0)
            else $error("ready bit on a free slot, occupied %h rdy1 %h rdy2 %h",
                        occupied, rdy1, rdy2);
    end

endmodule

`default_nettype wire

// ==== hw/rs_wakeup.sv ====
`default_nettype none

module rs_wakeup (
    input  logic                            wake_valid [rs_alu_pkg::NUM_WAKE],
    input  rs_alu_pkg::phys_tag_t           wake_tag   [rs_alu_pkg::NUM_WAKE],
    input  rs_alu_pkg::phys_tag_t           tag1_arr   [rs_alu_pkg::RS_DEPTH],
    input  rs_alu_pkg::phys_tag_t           tag2_arr   [rs_alu_pkg::RS_DEPTH],
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] rdy1,
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] rdy2,
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] occupied,
    input  rs_alu_pkg::phys_tag_t           src1_tag,
    input  rs_alu_pkg::phys_tag_t           src2_tag,
    output logic [rs_alu_pkg::RS_DEPTH-1:0] set1_mask,
    output logic [rs_alu_pkg::RS_DEPTH-1:0] set2_mask,
    output logic                            disp_hit1,
    output logic                            disp_hit2
);
    import rs_alu_pkg::*;

    always_comb begin
        set1_mask = '0;
        set2_mask = '0;
        disp_hit1 = 1'b0;
        disp_hit2 = 1'b0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            if (wake_valid[w]) begin
                for (int i = 0; i < RS_DEPTH; i++) begin
                    // only waiting operands of live entries
                    if (occupied[i] && !rdy1[i] && tag1_arr[i] == wake_tag[w])
                        set1_mask[i] = 1'b1;
                    if (occupied[i] && !rdy2[i] && tag2_arr[i] == wake_tag[w])
                        set2_mask[i] = 1'b1;
                end
                if (src1_tag == wake_tag[w]) disp_hit1 = 1'b1;  // same-cycle dispatch
                if (src2_tag == wake_tag[w]) disp_hit2 = 1'b1;
            end
        end
    end

    // a physical tag is produced by exactly one unit
    always_comb begin
        for (int a = 0; a < NUM_WAKE; a++)
            for (int b = a + 1; b < NUM_WAKE; b++)
                if (wake_valid[a] && wake_valid[b])
                    assert (wake_tag[a] != wake_tag[b])
                        else $error("buses %0d and %0d both broadcast tag %h", a, b, wake_tag[a]);
    end

endmodule

`default_nettype wire

// ==== hw/rs_entry_table.sv ====
`default_nettype none

module rs_entry_table (
    input  logic                       clk,
    input  logic                       reset,
    // dispatch
    input  logic                       dispatch_valid,
    input  rs_alu_pkg::inst_num_t      inst_num,
    input  rs_alu_pkg::word_t          pc,
    input  rs_alu_pkg::phys_tag_t      rd,
    input  rs_alu_pkg::alu_op_e        alu_op,
    input  logic                       src1_sel,
    input  logic                       src2_sel,
    input  rs_alu_pkg::word_t          imm,
    input  rs_alu_pkg::phys_tag_t      src1_tag,
    input  rs_alu_pkg::phys_tag_t      src2_tag,
    input  logic [1:0]                 src_ready,
    // wakeup and select results
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] set1_mask,
    input  logic [rs_alu_pkg::RS_DEPTH-1:0] set2_mask,
    input  logic                       disp_hit1,
    input  logic                       disp_hit2,
    input  logic                       grant_valid,
    input  rs_alu_pkg::rs_idx_t        grant_idx,
    // entry state
    output logic [rs_alu_pkg::RS_DEPTH-1:0] occupied,
    output logic [rs_alu_pkg::RS_DEPTH-1:0] rdy1,
    output logic [rs_alu_pkg::RS_DEPTH-1:0] rdy2,
    output rs_alu_pkg::phys_tag_t      tag1_arr [rs_alu_pkg::RS_DEPTH],
    output rs_alu_pkg::phys_tag_t      tag2_arr [rs_alu_pkg::RS_DEPTH],
    output rs_alu_pkg::rs_idx_t        head,
    // issue
    output logic                       issue_valid,
    output rs_alu_pkg::inst_num_t      issue_inst_num,
    output rs_alu_pkg::word_t          issue_pc,
    output rs_alu_pkg::phys_tag_t      issue_rd,
    output rs_alu_pkg::alu_op_e        issue_alu_op,
    output logic                       issue_src1_sel,
    output logic                       issue_src2_sel,
    output rs_alu_pkg::word_t          issue_imm,
    output rs_alu_pkg::phys_tag_t      issue_src1_tag,
    output rs_alu_pkg::phys_tag_t      issue_src2_tag
);
    import rs_alu_pkg::*;

    // payload storage
    inst_num_t           inst_num_arr [RS_DEPTH];
    word_t               pc_arr       [RS_DEPTH];
    phys_tag_t           rd_arr       [RS_DEPTH];
    alu_op_e             op_arr       [RS_DEPTH];
    word_t               imm_arr      [RS_DEPTH];
    logic [RS_DEPTH-1:0] sel1_arr;
    logic [RS_DEPTH-1:0] sel2_arr;

    rs_idx_t tail;
    logic    head_free;

    // head slot counts as free when it is being issued this edge
    assign head_free = !occupied[head] || (grant_valid && grant_idx == head);

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            inst_num_arr[tail] <= inst_num;
            pc_arr[tail]       <= pc;
            rd_arr[tail]       <= rd;
            op_arr[tail]       <= alu_op;
            sel1_arr[tail]     <= src1_sel;
            sel2_arr[tail]     <= src2_sel;
            imm_arr[tail]      <= imm;
            tag1_arr[tail]     <= src1_tag;
            tag2_arr[tail]     <= src2_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied       <= '0;
            rdy1           <= '0;
            rdy2           <= '0;
            head           <= '0;
            tail           <= '0;
            issue_valid    <= 1'b0;
            issue_inst_num <= '0;
            issue_pc       <= '0;
            issue_rd       <= '0;
            issue_alu_op   <= OP_ADD;
            issue_src1_sel <= 1'b0;
            issue_src2_sel <= 1'b0;
            issue_imm      <= '0;
            issue_src1_tag <= '0;
            issue_src2_tag <= '0;
        end else begin
            rdy1 <= rdy1 | set1_mask;   // broadcasts this cycle
            rdy2 <= rdy2 | set2_mask;

            if (dispatch_valid) begin
                occupied[tail] <= 1'b1;
                rdy1[tail]     <= src_ready[0] | disp_hit1;
                rdy2[tail]     <= src_ready[1] | disp_hit2;
                tail           <= tail + rs_idx_t'(1);
            end

            issue_valid <= grant_valid;
            if (grant_valid) begin
                issue_inst_num      <= inst_num_arr[grant_idx];
                issue_pc            <= pc_arr[grant_idx];
                issue_rd            <= rd_arr[grant_idx];
                issue_alu_op        <= op_arr[grant_idx];
                issue_src1_sel      <= sel1_arr[grant_idx];
                issue_src2_sel      <= sel2_arr[grant_idx];
                issue_imm           <= imm_arr[grant_idx];
                issue_src1_tag      <= tag1_arr[grant_idx];
                issue_src2_tag      <= tag2_arr[grant_idx];
                occupied[grant_idx] <= 1'b0;
                rdy1[grant_idx]     <= 1'b0;
                rdy2[grant_idx]     <= 1'b0;
            end

            // step over slots already reclaimed out of order
            if (head_free && head != tail)
                head <= head + rs_idx_t'(1);
        end
    end

    // no full signal upstream, so an overrun would silently clobber an entry
    a_dispatch_free: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid |-> !occupied[tail])
        else $error("dispatch into occupied slot %0d", tail);

    a_issue_from_live: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> $past(grant_valid && occupied[grant_idx]))
        else $error("issue of inst %h from a free slot", issue_inst_num);

endmodule

`default_nettype wire

// ==== hw/rs_alu_pkg.sv ====
`default_nettype none

package rs_alu_pkg;

    // station geometry
    localparam int RS_DEPTH  = 16;
    localparam int RS_WINDOW = 8;   // slots after head that issue may pick from
    localparam int RS_IDX_W  = $clog2(RS_DEPTH);

    // broadcast buses: 0 alu, 1 mul, 2 load
    localparam int NUM_WAKE = 3;

    localparam int TAG_W  = 8;
    localparam int WORD_W = 32;

    typedef logic [RS_IDX_W-1:0] rs_idx_t;
    typedef logic [TAG_W-1:0]    phys_tag_t;
    typedef logic [WORD_W-1:0]   inst_num_t;
    typedef logic [WORD_W-1:0]   word_t;     // pc and immediate

    // alu opcodes, carried through the station untouched
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire
